// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert --timescale 1ns/10ps
TOP       := tb_host_output
FILELIST  := verilog.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST)) hoi_defines.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== hoi_defines.svh ====
// shared constants; slot count may be 2 to 4, gap length must stay a power of two
`ifndef HOI_DEFINES_SVH
`define HOI_DEFINES_SVH

// ********************************************************************
// word and field widths
// ********************************************************************
`define HOI_WORD_W        134
`define HOI_PAYLOAD_W     128
`define HOI_TAG_W         48

// staging depth, pointers wrap at this count
`define HOI_NUM_SLOTS     2

// ********************************************************************
// word codes in bits 133:132
// ********************************************************************
`define HOI_CODE_HEAD     2'b01
`define HOI_CODE_BODY     2'b11
`define HOI_CODE_TAIL     2'b10

// ethertype rewrite
`define HOI_ETH_TSN       16'h1800
`define HOI_ETH_IP        16'h0800

// ********************************************************************
// line framing
// ********************************************************************
`define HOI_PREAMBLE_BYTE 8'h55
`define HOI_SFD_BYTE      8'hD5
`define HOI_PREAMBLE_LEN  7
// 12 bytes interframe gap plus 4 held back for the crc
`define HOI_GAP_CYCLES    16

`endif

// ==== hoi_frame_editor.sv ====
// descriptor must be written before its head word; writes are accepted only with o_pkt_rd_req high
`default_nettype none
`timescale 1ns/10ps

`include "hoi_defines.svh"

module hoi_frame_editor (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire hoi_pkg::hoi_tag_t            i_tsn_tag,
    input  wire logic                         i_dmac_replace_flag,
    input  wire logic                         i_pkt_descriptor_wr,
    input  wire hoi_pkg::hoi_word_t           i_pkt_data,
    input  wire logic                         i_pkt_data_wr,
    input  wire logic [`HOI_NUM_SLOTS-1:0]    i_slot_full,
    output logic                              o_pkt_rd_req,
    output logic                              o_pkt_last_cycle_rx,
    output logic [`HOI_NUM_SLOTS-1:0]         o_slot_wr,
    output hoi_pkg::hoi_word_t                o_slot_word
);

    import hoi_pkg::*;

    localparam int PTR_W = (`HOI_NUM_SLOTS > 1) ? $clog2(`HOI_NUM_SLOTS) : 1;

    hoi_tag_t   tag_q;
    logic       replace_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic       accept;

    // ********************************************************************
    // descriptor cache
    // ********************************************************************
    always_ff @(posedge i_clk) begin
        if (i_pkt_descriptor_wr) begin
            tag_q <= i_tsn_tag;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            replace_q <= 1'b0;
        end else if (i_pkt_descriptor_wr) begin
            replace_q <= i_dmac_replace_flag;
        end
    end

    // ********************************************************************
    // slot write side
    // ********************************************************************
    // only the slot under the pointer is offered, keeps frame order
    assign o_pkt_rd_req = ~i_slot_full[wr_ptr_q];
    assign accept       = i_pkt_data_wr & o_pkt_rd_req;

    always_comb begin
        o_slot_wr           = '0;
        o_slot_wr[wr_ptr_q] = accept;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
        end else if (accept) begin
            if (wr_ptr_q == PTR_W'(`HOI_NUM_SLOTS - 1)) begin
                wr_ptr_q <= '0;
            end else begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    // head word edits, body and tail pass as is
    always_comb begin
        o_slot_word = i_pkt_data;
        if (i_pkt_data.code == `HOI_CODE_HEAD) begin
            if (replace_q) begin
                o_slot_word.payload.head.dmac = tag_q;
            end
            if (i_pkt_data.payload.head.ethertype == `HOI_ETH_TSN) begin
                o_slot_word.payload.head.ethertype = `HOI_ETH_IP;
            end
        end
    end

    // tail seen on the input
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pkt_last_cycle_rx <= 1'b0;
        end else begin
            o_pkt_last_cycle_rx <= accept && (i_pkt_data.code == `HOI_CODE_TAIL);
        end
    end

endmodule

`default_nettype wire

// ==== hoi_frame_tx.sv ====
// no phy back-pressure; a missing word inside a frame stalls with o_data_wr low
`default_nettype none
`timescale 1ns/10ps

`include "hoi_defines.svh"

module hoi_frame_tx (
    input  wire logic                                          i_clk,
    input  wire logic                                          i_rst_n,
    input  wire logic [`HOI_NUM_SLOTS-1:0]                     i_slot_full,
    input  wire hoi_pkg::hoi_word_t [`HOI_NUM_SLOTS-1:0]       i_slot_words,
    output logic [`HOI_NUM_SLOTS-1:0]                          o_slot_release,
    output hoi_pkg::hoi_byte_t                                 o_data,
    output logic                                               o_data_wr,
    output logic                                               o_pkt_cnt_pulse
);

    import hoi_pkg::*;

    localparam int PTR_W    = (`HOI_NUM_SLOTS > 1) ? $clog2(`HOI_NUM_SLOTS) : 1;
    localparam int BYTES    = `HOI_PAYLOAD_W / 8;
    localparam int CNT_W    = $clog2(BYTES);
    localparam int GAP_W    = $clog2(`HOI_GAP_CYCLES);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_PREAMBLE = 2'd1;
    localparam logic [1:0] ST_PAYLOAD  = 2'd2;
    localparam logic [1:0] ST_GAP      = 2'd3;

    logic [1:0]       state_q, state_d;
    logic [CNT_W-1:0] byte_cnt_q, byte_cnt_d;
    logic [GAP_W-1:0] gap_cnt_q, gap_cnt_d;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             rd_ptr_adv;
    hoi_byte_t        data_d;
    logic             data_wr_d;
    logic             cnt_pulse_d;

    hoi_word_t        cur_word;
    logic             cur_full;
    logic [CNT_W-1:0] last_idx;
    logic             word_last;

    // ********************************************************************
    // current slot view
    // ********************************************************************
    assign cur_word = i_slot_words[rd_ptr_q];
    assign cur_full = i_slot_full[rd_ptr_q];

    // tail stops pad bytes early
    assign last_idx  = (cur_word.code == `HOI_CODE_TAIL) ?
                       (CNT_W'(BYTES - 1) - cur_word.pad) : CNT_W'(BYTES - 1);
    assign word_last = (byte_cnt_q == last_idx);

    // ********************************************************************
    // frame FSM, next state
    // ********************************************************************
    always_comb begin
        state_d        = state_q;
        byte_cnt_d     = byte_cnt_q;
        gap_cnt_d      = gap_cnt_q;
        rd_ptr_adv     = 1'b0;
        data_d         = o_data;
        data_wr_d      = 1'b0;
        cnt_pulse_d    = 1'b0;
        o_slot_release = '0;

        case (state_q)
            ST_IDLE: begin
                byte_cnt_d = '0;
                if (cur_full) begin
                    if (cur_word.code == `HOI_CODE_HEAD) begin
                        data_d      = `HOI_PREAMBLE_BYTE;
                        data_wr_d   = 1'b1;
                        cnt_pulse_d = 1'b1;
                        byte_cnt_d  = CNT_W'(1);
                        state_d     = ST_PREAMBLE;
                    end else begin
                        // stray word outside a frame, drop it
                        o_slot_release[rd_ptr_q] = 1'b1;
                        rd_ptr_adv               = 1'b1;
                    end
                end
            end

            ST_PREAMBLE: begin
                data_wr_d = 1'b1;
                if (byte_cnt_q == CNT_W'(`HOI_PREAMBLE_LEN)) begin
                    data_d     = `HOI_SFD_BYTE;
                    byte_cnt_d = '0;
                    state_d    = ST_PAYLOAD;
                end else begin
                    data_d     = `HOI_PREAMBLE_BYTE;
                    byte_cnt_d = byte_cnt_q + 1'b1;
                end
            end

            ST_PAYLOAD: begin
                // wait here with data_wr low until the next word shows up
                if (cur_full) begin
                    data_d     = cur_word.payload.octets[byte_cnt_q];
                    data_wr_d  = 1'b1;
                    byte_cnt_d = byte_cnt_q + 1'b1;
                    if (word_last) begin
                        o_slot_release[rd_ptr_q] = 1'b1;
                        rd_ptr_adv               = 1'b1;
                        byte_cnt_d               = '0;
                        if (cur_word.code == `HOI_CODE_TAIL) begin
                            gap_cnt_d = '0;
                            state_d   = ST_GAP;
                        end
                    end
                end
            end

            default: begin
                // ST_GAP, line stays quiet
                if (gap_cnt_q == GAP_W'(`HOI_GAP_CYCLES - 1)) begin
                    state_d = ST_IDLE;
                end else begin
                    gap_cnt_d = gap_cnt_q + 1'b1;
                end
            end
        endcase
    end

    // ********************************************************************
    // registers
    // ********************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q         <= ST_IDLE;
            byte_cnt_q      <= '0;
            gap_cnt_q       <= '0;
            rd_ptr_q        <= '0;
            o_data_wr       <= 1'b0;
            o_pkt_cnt_pulse <= 1'b0;
        end else begin
            state_q         <= state_d;
            byte_cnt_q      <= byte_cnt_d;
            gap_cnt_q       <= gap_cnt_d;
            o_data_wr       <= data_wr_d;
            o_pkt_cnt_pulse <= cnt_pulse_d;
            if (rd_ptr_adv) begin
                if (rd_ptr_q == PTR_W'(`HOI_NUM_SLOTS - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
        end
    end

    // output byte, qualified by o_data_wr
    always_ff @(posedge i_clk) begin
        o_data <= data_d;
    end

endmodule

`default_nettype wire

// ==== hoi_pkg.sv ====
// word types only; the head view carries dmac, smac, ethertype and tail, no mid field
`default_nettype none

`include "hoi_defines.svh"

package hoi_pkg;

    // ********************************************************************
    // basic fields
    // ********************************************************************
    typedef logic [7:0] hoi_byte_t;

    typedef logic [`HOI_TAG_W-1:0] hoi_tag_t;

    // head word layout, ethertype lands on payload bits 31:16
    typedef struct packed {
        logic [47:0] dmac;
        logic [47:0] smac;
        logic [15:0] ethertype;
        logic [15:0] tail;
    } hoi_head_t;

    // ********************************************************************
    // payload, seen as head fields or as a byte stream
    // ********************************************************************
    // octets[0] is the most significant byte, sent first
    typedef union packed {
        hoi_head_t                             head;
        hoi_byte_t [0:(`HOI_PAYLOAD_W/8)-1]    octets;
    } hoi_payload_u;

    // full packet word from the host side
    typedef struct packed {
        logic [1:0]   code;
        logic [3:0]   pad;      // invalid trailing bytes, tail word only
        hoi_payload_u payload;
    } hoi_word_t;

endpackage

`default_nettype wire

// ==== hoi_word_slot.sv ====
// write and release never arrive together; word content is undefined until first write
`default_nettype none
`timescale 1ns/10ps

`include "hoi_defines.svh"

module hoi_word_slot (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_wr,
    input  wire hoi_pkg::hoi_word_t i_word,
    input  wire logic               i_release,
    output logic                    o_full,
    output hoi_pkg::hoi_word_t      o_word
);

    // raw storage for one host word
    logic [`HOI_WORD_W-1:0] word_q;

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            word_q <= i_word;
        end
    end

    // occupancy
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_full <= 1'b0;
        end else if (i_wr) begin
            o_full <= 1'b1;
        end else if (i_release) begin
            o_full <= 1'b0;
        end
    end

    assign o_word = word_q;

endmodule

`default_nettype wire

// ==== host_output_top.sv ====
// host words in, phy bytes out; PTP correction and crc generation are not done here
`default_nettype none
`timescale 1ns/10ps

`include "hoi_defines.svh"

module host_output_top (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire hoi_pkg::hoi_tag_t  i_tsn_tag,
    input  wire logic               i_dmac_replace_flag,
    input  wire logic               i_pkt_descriptor_wr,
    input  wire hoi_pkg::hoi_word_t i_pkt_data,
    input  wire logic               i_pkt_data_wr,
    output logic                    o_pkt_rd_req,
    output logic                    o_pkt_last_cycle_rx,
    output logic                    o_pkt_cnt_pulse,
    output hoi_pkg::hoi_byte_t      o_data,
    output logic                    o_data_wr
);

    import hoi_pkg::*;

    logic [`HOI_NUM_SLOTS-1:0]      slot_full;
    logic [`HOI_NUM_SLOTS-1:0]      slot_wr;
    logic [`HOI_NUM_SLOTS-1:0]      slot_release;
    hoi_word_t                      slot_word;
    hoi_word_t [`HOI_NUM_SLOTS-1:0] slot_words;

    // ********************************************************************
    // input side, descriptor cache and header edits
    // ********************************************************************
    hoi_frame_editor u_editor (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_tsn_tag           (i_tsn_tag),
        .i_dmac_replace_flag (i_dmac_replace_flag),
        .i_pkt_descriptor_wr (i_pkt_descriptor_wr),
        .i_pkt_data          (i_pkt_data),
        .i_pkt_data_wr       (i_pkt_data_wr),
        .i_slot_full         (slot_full),
        .o_pkt_rd_req        (o_pkt_rd_req),
        .o_pkt_last_cycle_rx (o_pkt_last_cycle_rx),
        .o_slot_wr           (slot_wr),
        .o_slot_word         (slot_word)
    );

    // ********************************************************************
    // staging slots, filled and drained round-robin
    // ********************************************************************
    for (genvar g = 0; g < `HOI_NUM_SLOTS; g++) begin : g_slot
        hoi_word_slot u_slot (
            .i_clk     (i_clk),
            .i_rst_n   (i_rst_n),
            .i_wr      (slot_wr[g]),
            .i_word    (slot_word),
            .i_release (slot_release[g]),
            .o_full    (slot_full[g]),
            .o_word    (slot_words[g])
        );
    end

    // phy side framing
    hoi_frame_tx u_tx (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_slot_full     (slot_full),
        .i_slot_words    (slot_words),
        .o_slot_release  (slot_release),
        .o_data          (o_data),
        .o_data_wr       (o_data_wr),
        .o_pkt_cnt_pulse (o_pkt_cnt_pulse)
    );

endmodule

`default_nettype wire

// ==== tb_host_output.sv ====
// 40 random frames through host_output_top; the source keeps the slots fed so no frame stalls
`default_nettype none
`timescale 1ns/10ps

`include "hoi_defines.svh"

module tb_host_output;

    import hoi_pkg::*;

    localparam int NUM_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 150;
    localparam int PAYLOAD_BYTES  = `HOI_PAYLOAD_W / 8;
    localparam int HDR_BYTES      = `HOI_PREAMBLE_LEN + 1;

    logic        clk = 1'b0;
    logic        rst_n;
    hoi_tag_t    tsn_tag;
    logic        dmac_replace_flag;
    logic        pkt_descriptor_wr;
    hoi_word_t   pkt_data;
    logic        pkt_data_wr;
    logic        pkt_rd_req;
    logic        pkt_last_cycle_rx;
    logic        pkt_cnt_pulse;
    hoi_byte_t   data;
    logic        data_wr;

    logic [31:0] lfsr_q = 32'h524b_513e;

    // expected payload bytes of all frames, and each frame's payload length
    hoi_byte_t   exp_bytes[$];
    int          exp_len[$];

    // line monitor state
    logic        in_frame = 1'b0;
    int          pos = 0;
    int          frame_len = 0;
    int          gap_cycles = 0;
    int          frames_rx = 0;
    int          cnt_pulses = 0;
    int          last_pulses = 0;
    int          cycles = 0;

    host_output_top i_dut (
        .i_clk               (clk),
        .i_rst_n             (rst_n),
        .i_tsn_tag           (tsn_tag),
        .i_dmac_replace_flag (dmac_replace_flag),
        .i_pkt_descriptor_wr (pkt_descriptor_wr),
        .i_pkt_data          (pkt_data),
        .i_pkt_data_wr       (pkt_data_wr),
        .o_pkt_rd_req        (pkt_rd_req),
        .o_pkt_last_cycle_rx (pkt_last_cycle_rx),
        .o_pkt_cnt_pulse     (pkt_cnt_pulse),
        .o_data              (data),
        .o_data_wr           (data_wr)
    );

    always #50 clk = ~clk;

    // ********************************************************************
    // helpers
    // ********************************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            end_with_failure();
        end
    endtask

    function automatic string byte_region(input int off);
        if (off >= PAYLOAD_BYTES) begin
            return "payload";
        end
        if (off < 6) begin
            return "head_dmac";
        end
        if (off < 12) begin
            return "head_smac";
        end
        if (off < 14) begin
            return "head_ethertype";
        end
        return "head_tail";
    endfunction

    // ********************************************************************
    // frame source and reference model
    // ********************************************************************
    task automatic send_frame();
        hoi_word_t    words [5];
        hoi_payload_u edited;
        hoi_tag_t     tag;
        logic         replace;
        logic [63:0]  hi;
        logic [63:0]  lo;
        int           nwords;
        int           nbytes;
        int           total;

        draw_bits(2, lo);
        nwords = 2 + int'(lo[1:0]);
        for (int w = 0; w < nwords; w++) begin
            draw_bits(64, hi);
            draw_bits(64, lo);
            words[w].payload = {hi, lo};
            draw_bits(4, lo);
            words[w].pad = lo[3:0];
            if (w == 0) begin
                words[w].code = `HOI_CODE_HEAD;
            end else if (w == nwords - 1) begin
                words[w].code = `HOI_CODE_TAIL;
            end else begin
                words[w].code = `HOI_CODE_BODY;
            end
        end
        // about half the frames carry the tsn ethertype
        draw_bits(1, lo);
        if (lo[0]) begin
            words[0].payload.head.ethertype = `HOI_ETH_TSN;
        end
        draw_bits(48, lo);
        tag = lo[47:0];
        draw_bits(1, lo);
        replace = lo[0];

        // expected line bytes: edited head, then words msb first, tail cut by pad
        total = 0;
        for (int w = 0; w < nwords; w++) begin
            edited = words[w].payload;
            if (words[w].code == `HOI_CODE_HEAD) begin
                if (replace) begin
                    edited.head.dmac = tag;
                end
                if (edited.head.ethertype == `HOI_ETH_TSN) begin
                    edited.head.ethertype = `HOI_ETH_IP;
                end
            end
            if (words[w].code == `HOI_CODE_TAIL) begin
                nbytes = PAYLOAD_BYTES - int'(words[w].pad);
            end else begin
                nbytes = PAYLOAD_BYTES;
            end
            for (int b = 0; b < nbytes; b++) begin
                exp_bytes.push_back(edited.octets[b]);
            end
            total += nbytes;
        end
        exp_len.push_back(total);

        // idle between frames, then the descriptor ahead of the head word
        draw_bits(3, lo);
        repeat (int'(lo[2:0])) next_cycle();
        tsn_tag           = tag;
        dmac_replace_flag = replace;
        pkt_descriptor_wr = 1'b1;
        next_cycle();
        pkt_descriptor_wr = 1'b0;

        for (int w = 0; w < nwords; w++) begin
            while (!pkt_rd_req) begin
                next_cycle();
            end
            pkt_data    = words[w];
            pkt_data_wr = 1'b1;
            next_cycle();
            pkt_data_wr = 1'b0;
        end
    endtask

    // ********************************************************************
    // line monitor, sampled on the falling edge
    // ********************************************************************
    always @(negedge clk) begin
        if (rst_n) begin
            check($sformatf("frame %0d cnt_pulse", frames_rx),
                  64'(data_wr && !in_frame), 64'(pkt_cnt_pulse));
            if (pkt_cnt_pulse) begin
                cnt_pulses++;
            end
            if (pkt_last_cycle_rx) begin
                last_pulses++;
            end
            if (data_wr) begin
                if (!in_frame) begin
                    if (exp_len.size() == 0) begin
                        $display("frame started on the line with no frame outstanding");
                        end_with_failure();
                    end else if (frames_rx > 0 && gap_cycles < `HOI_GAP_CYCLES) begin
                        $display("only %0d idle cycles before frame %0d, need %0d",
                                 gap_cycles, frames_rx, `HOI_GAP_CYCLES);
                        end_with_failure();
                    end else begin
                        frame_len = exp_len.pop_front();
                        in_frame  = 1'b1;
                        pos       = 0;
                    end
                end
                if (pos < `HOI_PREAMBLE_LEN) begin
                    check($sformatf("frame %0d preamble", frames_rx),
                          64'(`HOI_PREAMBLE_BYTE), 64'(data));
                end else if (pos == `HOI_PREAMBLE_LEN) begin
                    check($sformatf("frame %0d sfd", frames_rx), 64'(`HOI_SFD_BYTE), 64'(data));
                end else begin
                    check($sformatf("frame %0d %s", frames_rx, byte_region(pos - HDR_BYTES)),
                          64'(exp_bytes.pop_front()), 64'(data));
                end
                pos++;
                if (pos == HDR_BYTES + frame_len) begin
                    in_frame   = 1'b0;
                    frames_rx++;
                    gap_cycles = 0;
                end
            end else if (in_frame) begin
                $display("o_data_wr dropped inside frame %0d at byte %0d", frames_rx, pos);
                end_with_failure();
            end else begin
                gap_cycles++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d frames received",
                     cycles, frames_rx, NUM_FRAMES);
            end_with_failure();
        end
    end

    // ********************************************************************
    // main sequence
    // ********************************************************************
    initial begin
        rst_n             = 1'b1;
        tsn_tag           = '0;
        dmac_replace_flag = 1'b0;
        pkt_descriptor_wr = 1'b0;
        pkt_data          = '0;
        pkt_data_wr       = 1'b0;
        // falling edge after time zero so every flop sees it
        #1;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("reset_rd_req", 64'd1, 64'(pkt_rd_req));
        check("reset_data_wr", 64'd0, 64'(data_wr));
        check("reset_last_cycle_rx", 64'd0, 64'(pkt_last_cycle_rx));

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
        end
        wait (frames_rx == NUM_FRAMES);

        check("cnt_pulses", 64'(NUM_FRAMES), 64'(cnt_pulses));
        check("last_cycle_pulses", 64'(NUM_FRAMES), 64'(last_pulses));
        if (exp_bytes.size() == 0 && exp_len.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d expected bytes never appeared on the line", exp_bytes.size());
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== tb_host_output_asserts.sv ====
// bound into host_output_top; watches the input handshake and quiet outputs during reset
`default_nettype none
`timescale 1ns/10ps

module tb_host_output_asserts (
    input wire logic i_clk,
    input wire logic i_rst_n,
    input wire logic i_pkt_data_wr,
    input wire logic i_pkt_rd_req,
    input wire logic i_data_wr,
    input wire logic i_pkt_cnt_pulse
);

    // ********************************************************************
    // handshake and reset
    // ********************************************************************
    // source may only write into an offered slot
    a_wr_needs_req : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pkt_data_wr |-> i_pkt_rd_req)
        else $error("pkt_data_wr high while pkt_rd_req is low");

    a_quiet_in_reset : assert property (@(posedge i_clk)
        !i_rst_n |-> (!i_data_wr && !i_pkt_cnt_pulse))
        else $error("line output active while reset is asserted");

    // one pulse per frame start
    a_single_cnt_pulse : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pkt_cnt_pulse |=> !i_pkt_cnt_pulse)
        else $error("pkt_cnt_pulse high in two consecutive cycles");

endmodule

bind host_output_top tb_host_output_asserts u_asserts (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_pkt_data_wr   (i_pkt_data_wr),
    .i_pkt_rd_req    (o_pkt_rd_req),
    .i_data_wr       (o_data_wr),
    .i_pkt_cnt_pulse (o_pkt_cnt_pulse)
);

`default_nettype wire

// ==== verilog.f ====
+incdir+.
hoi_pkg.sv
hoi_frame_editor.sv
hoi_word_slot.sv
hoi_frame_tx.sv
host_output_top.sv
tb_host_output_asserts.sv
tb_host_output.sv
